// ==== logic/gpu_pkg.sv ====
`default_nettype none

package gpu_pkg;

    // data and address width on every bus
    localparam int WORD_W = 32;

    typedef logic [WORD_W-1:0] word_t;

    // host commands, one full word on recv_instr
    typedef enum logic [WORD_W-1:0] {
        NOP           = 32'd0,
        COPY_TO_GPU   = 32'd1,
        COPY_FROM_GPU = 32'd2,
        KERNEL_LAUNCH = 32'd3
    } host_op_e;

    // every command is followed by this many words on in_data
    localparam int CMD_PARAMS = 2;

    // kernel word layout
    // opcode sits in the top nibble, argument in the low half
    localparam int KOP_MSB = 31;
    localparam int KOP_LSB = 28;
    localparam int KOP_W   = KOP_MSB - KOP_LSB + 1;
    localparam int KARG_W  = 16;

    typedef enum logic [KOP_W-1:0] {
        HALT  = 4'd0,
        LOAD  = 4'd1,
        ADD   = 4'd2,
        STORE = 4'd3,
        ADDI  = 4'd4,
        JNZ   = 4'd5,
        JMP   = 4'd6
    } kernel_op_e;

    // status word sent back when a launch ends
    localparam word_t ST_HALTED  = 32'd0;
    localparam word_t ST_TIMEOUT = 32'd1;

endpackage

`default_nettype wire

// ==== logic/device_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

module device_mem #(
    parameter int MEM_WORDS = 1024
) (
    input  wire                           clk,
    // host side, used by the copy engines
    input  wire                           h_we,
    input  wire [$clog2(MEM_WORDS)-1:0]   h_addr,
    input  wire gpu_pkg::word_t           h_wdata,
    output gpu_pkg::word_t                h_rdata,
    // core side, used by fetch and load/store
    input  wire                           c_we,
    input  wire [$clog2(MEM_WORDS)-1:0]   c_addr,
    input  wire gpu_pkg::word_t           c_wdata,
    output gpu_pkg::word_t                c_rdata
);
    import gpu_pkg::*;

    // word storage, contents undefined until written
    word_t mem [MEM_WORDS];

    // both ports in one block
    // the controller keeps off memory while the core runs, so no collisions
    always_ff @(posedge clk) begin
        if (h_we) begin
            mem[h_addr] <= h_wdata;
        end
        // read returns the old word on a same-cycle write
        h_rdata <= mem[h_addr];

        if (c_we) begin
            mem[c_addr] <= c_wdata;
        end
        c_rdata <= mem[c_addr];
    end

endmodule

`default_nettype wire

// ==== logic/host_controller.sv ====
`timescale 1ns/10ps
`default_nettype none

module host_controller #(
    parameter int MEM_WORDS    = 1024,
    parameter int TIMEOUT_UNIT = 1000
) (
    input  wire                           clk,
    input  wire                           rst,
    // driver side
    input  wire gpu_pkg::word_t           recv_instr,
    input  wire gpu_pkg::word_t           in_data,
    output gpu_pkg::word_t                out_data,
    output logic                          out_valid,
    output logic                          busy,
    // host port of device memory
    output logic                          h_we,
    output logic [$clog2(MEM_WORDS)-1:0]  h_addr,
    output gpu_pkg::word_t                h_wdata,
    input  wire gpu_pkg::word_t           h_rdata,
    // core control
    output logic                          start,
    output logic [$clog2(MEM_WORDS)-1:0]  start_pc,
    output logic                          abort,
    input  wire                           done
);
    import gpu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);
    localparam int PW = (CMD_PARAMS > 1) ? $clog2(CMD_PARAMS) : 1;

    typedef enum logic [2:0] {
        IDLE,
        RECV_PARAMS,
        RECEIVE_DATA,
        SEND_DATA,
        SEND_DRAIN,
        RUN_KERNEL,
        WAIT_ABORT,
        REPORT
    } state_e;

    // registered state
    state_e         state;
    host_op_e       instr;
    logic [PW-1:0]  param_pos;
    word_t          params [CMD_PARAMS];
    // word index of the next transfer
    word_t          data_addr;
    // copy stops when data_addr reaches this, so no separate down counter
    word_t          end_addr;
    word_t          timeout_lim;
    word_t          wd_cnt;
    word_t          status;
    // a read was issued last cycle, data is on h_rdata now
    logic           rd_valid;

    // next-state values
    state_e         n_state;
    host_op_e       n_instr;
    logic [PW-1:0]  n_param_pos;
    word_t          n_params [CMD_PARAMS];
    word_t          n_data_addr;
    word_t          n_end_addr;
    word_t          n_timeout_lim;
    word_t          n_wd_cnt;
    word_t          n_status;
    logic           n_rd_valid;
    logic           n_start;
    logic           n_abort;
    logic [AW-1:0]  n_start_pc;

    always_comb begin
        n_state       = state;
        n_instr       = instr;
        n_param_pos   = param_pos;
        n_params      = params;
        n_data_addr   = data_addr;
        n_end_addr    = end_addr;
        n_timeout_lim = timeout_lim;
        n_wd_cnt      = wd_cnt;
        n_status      = status;
        n_start_pc    = start_pc;
        // pulses default low
        n_rd_valid    = 1'b0;
        n_start       = 1'b0;
        n_abort       = 1'b0;

        case (state)
            IDLE: begin
                n_param_pos = '0;
                // nop and unknown opcodes leave us idle
                if (recv_instr inside {COPY_TO_GPU, COPY_FROM_GPU, KERNEL_LAUNCH}) begin
                    n_instr = host_op_e'(recv_instr);
                    n_state = RECV_PARAMS;
                end
            end
            RECV_PARAMS: begin
                // params come on in_data, so recv_instr never gets misread as a param
                n_params[param_pos] = in_data;
                n_param_pos         = param_pos + 1'b1;
                if (param_pos == PW'(CMD_PARAMS - 1)) begin
                    n_param_pos = '0;
                    case (instr)
                        COPY_TO_GPU, COPY_FROM_GPU: begin
                            // byte address and byte count, low two bits dropped
                            n_data_addr = n_params[0] >> 2;
                            n_end_addr  = (n_params[0] >> 2) + (n_params[1] >> 2);
                            if (n_params[1][WORD_W-1:2] == '0) begin
                                n_state = IDLE;
                            end else if (instr == COPY_TO_GPU) begin
                                n_state = RECEIVE_DATA;
                            end else begin
                                n_state = SEND_DATA;
                            end
                        end
                        KERNEL_LAUNCH: begin
                            n_start_pc    = AW'(n_params[0] >> 2);
                            // zero means run forever
                            n_timeout_lim = n_params[1] * word_t'(TIMEOUT_UNIT);
                            n_wd_cnt      = '0;
                            n_start       = 1'b1;
                            n_state       = RUN_KERNEL;
                        end
                        default: begin
                            n_state = IDLE;
                        end
                    endcase
                end
            end
            RECEIVE_DATA: begin
                // write happens this edge via h_we
                n_data_addr = data_addr + 1'b1;
                if (n_data_addr == end_addr) begin
                    n_state = IDLE;
                end
            end
            SEND_DATA: begin
                n_rd_valid  = 1'b1;
                n_data_addr = data_addr + 1'b1;
                if (n_data_addr == end_addr) begin
                    n_state = SEND_DRAIN;
                end
            end
            SEND_DRAIN: begin
                // last word goes out this cycle
                n_state = IDLE;
            end
            RUN_KERNEL: begin
                n_wd_cnt = wd_cnt + 1'b1;
                // a halt wins over a timeout hitting in the same cycle
                if (done) begin
                    n_status = ST_HALTED;
                    n_state  = REPORT;
                end else if (timeout_lim != '0 && n_wd_cnt == timeout_lim) begin
                    n_abort = 1'b1;
                    n_state = WAIT_ABORT;
                end
            end
            WAIT_ABORT: begin
                // core acks the abort with done
                if (done) begin
                    n_status = ST_TIMEOUT;
                    n_state  = REPORT;
                end
            end
            REPORT: begin
                n_state = IDLE;
            end
            default: begin
                n_state = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state       <= IDLE;
            instr       <= NOP;
            param_pos   <= '0;
            params      <= '{default: '0};
            data_addr   <= '0;
            end_addr    <= '0;
            timeout_lim <= '0;
            wd_cnt      <= '0;
            status      <= '0;
            rd_valid    <= 1'b0;
            start       <= 1'b0;
            abort       <= 1'b0;
            start_pc    <= '0;
        end else begin
            state       <= n_state;
            instr       <= n_instr;
            param_pos   <= n_param_pos;
            params      <= n_params;
            data_addr   <= n_data_addr;
            end_addr    <= n_end_addr;
            timeout_lim <= n_timeout_lim;
            wd_cnt      <= n_wd_cnt;
            status      <= n_status;
            rd_valid    <= n_rd_valid;
            start       <= n_start;
            abort       <= n_abort;
            start_pc    <= n_start_pc;
        end
    end

    // memory host port
    assign h_we    = (state == RECEIVE_DATA);
    assign h_addr  = data_addr[AW-1:0];
    assign h_wdata = in_data;

    // driver outputs
    // read data is shown straight off the memory port, status in REPORT
    assign busy      = (state != IDLE);
    assign out_valid = rd_valid | (state == REPORT);
    assign out_data  = rd_valid            ? h_rdata :
                       (state == REPORT)   ? status  : '0;

endmodule

`default_nettype wire

// ==== logic/accum_core.sv ====
`timescale 1ns/10ps
`default_nettype none

module accum_core #(
    parameter int MEM_WORDS = 1024
) (
    input  wire                           clk,
    input  wire                           rst,
    // launch control from the host controller
    input  wire                           start,
    input  wire [$clog2(MEM_WORDS)-1:0]   start_pc,
    input  wire                           abort,
    output logic                          done,
    // core port of device memory
    output logic                          c_we,
    output logic [$clog2(MEM_WORDS)-1:0]  c_addr,
    output gpu_pkg::word_t                c_wdata,
    input  wire gpu_pkg::word_t           c_rdata
);
    import gpu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    typedef enum logic [1:0] {
        C_IDLE,
        C_FETCH,
        C_DECODE,
        C_OPERAND
    } core_state_e;

    core_state_e        state;
    logic [AW-1:0]      pc;
    word_t              acc;
    // opcode held over into the operand cycle
    kernel_op_e         op_q;

    // fields of the word on c_rdata, valid in decode
    kernel_op_e         kop;
    logic [KARG_W-1:0]  karg;
    logic [AW-1:0]      karg_idx;
    word_t              imm_ext;

    assign kop      = kernel_op_e'(c_rdata[KOP_MSB:KOP_LSB]);
    assign karg     = c_rdata[KARG_W-1:0];
    // word indices wrap at the memory depth
    assign karg_idx = AW'(karg);
    // addi immediate is signed
    assign imm_ext  = {{(WORD_W-KARG_W){karg[KARG_W-1]}}, karg};

    // memory port
    // fetch address is pc, decode redirects to the operand for load/add/store
    always_comb begin
        c_we    = 1'b0;
        c_addr  = pc;
        c_wdata = acc;
        if (state == C_DECODE && kop inside {LOAD, ADD, STORE}) begin
            c_addr = karg_idx;
        end
        if (state == C_DECODE && kop == STORE) begin
            c_we = 1'b1;
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state <= C_IDLE;
            pc    <= '0;
            acc   <= '0;
            op_q  <= HALT;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            // abort beats everything, even when already idle
            if (abort) begin
                state <= C_IDLE;
                done  <= 1'b1;
            end else begin
                case (state)
                    C_IDLE: begin
                        if (start) begin
                            pc    <= start_pc;
                            acc   <= '0;
                            state <= C_FETCH;
                        end
                    end
                    C_FETCH: begin
                        // read of the instruction word is in flight
                        state <= C_DECODE;
                    end
                    C_DECODE: begin
                        op_q  <= kop;
                        pc    <= pc + 1'b1;
                        state <= C_FETCH;
                        case (kop)
                            HALT: begin
                                done  <= 1'b1;
                                state <= C_IDLE;
                            end
                            LOAD, ADD: begin
                                // operand read issued this cycle
                                state <= C_OPERAND;
                            end
                            ADDI: begin
                                acc <= acc + imm_ext;
                            end
                            JNZ: begin
                                if (acc != '0) begin
                                    pc <= karg_idx;
                                end
                            end
                            JMP: begin
                                pc <= karg_idx;
                            end
                            default: begin
                                // store already written, unknown ops fall through
                                state <= C_FETCH;
                            end
                        endcase
                    end
                    C_OPERAND: begin
                        // wraps at 32 bits
                        acc   <= (op_q == LOAD) ? c_rdata : acc + c_rdata;
                        state <= C_FETCH;
                    end
                    default: begin
                        state <= C_IDLE;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

// ==== logic/gpu_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpu_top #(
    parameter int MEM_WORDS    = 1024,
    parameter int TIMEOUT_UNIT = 1000
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire gpu_pkg::word_t  recv_instr,
    input  wire gpu_pkg::word_t  in_data,
    output gpu_pkg::word_t       out_data,
    output logic                 out_valid,
    output logic                 busy
);
    import gpu_pkg::*;

    localparam int AW = $clog2(MEM_WORDS);

    // host port of memory
    logic           h_we;
    logic [AW-1:0]  h_addr;
    word_t          h_wdata;
    word_t          h_rdata;

    // core port of memory
    logic           c_we;
    logic [AW-1:0]  c_addr;
    word_t          c_wdata;
    word_t          c_rdata;

    // launch handshake between controller and core
    logic           start;
    logic [AW-1:0]  start_pc;
    logic           abort;
    logic           done;

    host_controller #(
        .MEM_WORDS    (MEM_WORDS),
        .TIMEOUT_UNIT (TIMEOUT_UNIT)
    ) u_host_controller (
        .clk        (clk),
        .rst        (rst),
        .recv_instr (recv_instr),
        .in_data    (in_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .busy       (busy),
        .h_we       (h_we),
        .h_addr     (h_addr),
        .h_wdata    (h_wdata),
        .h_rdata    (h_rdata),
        .start      (start),
        .start_pc   (start_pc),
        .abort      (abort),
        .done       (done)
    );

    device_mem #(
        .MEM_WORDS (MEM_WORDS)
    ) u_device_mem (
        .clk     (clk),
        .h_we    (h_we),
        .h_addr  (h_addr),
        .h_wdata (h_wdata),
        .h_rdata (h_rdata),
        .c_we    (c_we),
        .c_addr  (c_addr),
        .c_wdata (c_wdata),
        .c_rdata (c_rdata)
    );

    accum_core #(
        .MEM_WORDS (MEM_WORDS)
    ) u_accum_core (
        .clk      (clk),
        .rst      (rst),
        .start    (start),
        .start_pc (start_pc),
        .abort    (abort),
        .done     (done),
        .c_we     (c_we),
        .c_addr   (c_addr),
        .c_wdata  (c_wdata),
        .c_rdata  (c_rdata)
    );

endmodule

`default_nettype wire

// ==== verif/gpu_properties.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpu_properties (
    input wire                  clk,
    input wire                  rst,
    input wire gpu_pkg::word_t  recv_instr,
    input wire                  out_valid,
    input wire                  busy
);
    import gpu_pkg::*;

    // read data and status only go out during a command
    valid_needs_busy: assert property (@(posedge clk) disable iff (!rst) out_valid |-> busy)
        else $error("out_valid high while busy is low");

    // first edge out of reset, nothing shown yet
    quiet_after_reset: assert property (@(posedge clk) $rose(rst) |-> !out_valid)
        else $error("out_valid high right after reset release");

    // busy rises only on an accepted opcode
    busy_needs_cmd: assert property (@(posedge clk) disable iff (!rst)
        $rose(busy) |-> $past(recv_instr) inside {COPY_TO_GPU, COPY_FROM_GPU, KERNEL_LAUNCH})
        else $error("busy rose without a valid command");

endmodule

bind gpu_top gpu_properties u_gpu_properties (
    .clk        (clk),
    .rst        (rst),
    .recv_instr (recv_instr),
    .out_valid  (out_valid),
    .busy       (busy)
);

`default_nettype wire

// ==== verif/gpu_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module gpu_tb;
    import gpu_pkg::*;

    localparam int MEM_WORDS    = 1024;
    localparam int TIMEOUT_UNIT = 16;
    // commands in the whole run, and the longest one with its idle gap
    localparam int NUM_CMDS     = 40;
    localparam int WORST_CMD    = 128;
    localparam int CYCLE_LIMIT  = NUM_CMDS * WORST_CMD + 32;
    // word areas for the kernel tests, above the copy test regions
    localparam int OPND_BASE    = 640;
    localparam int STORE_BASE   = 656;
    localparam int PROG_BASE    = 768;

    logic   clk;
    logic   rst;
    word_t  recv_instr;
    word_t  in_data;
    word_t  out_data;
    logic   out_valid;
    logic   busy;

    word_t  shadow [MEM_WORDS];
    // words to send with a copy in, words seen with out_valid
    word_t  buf_q [$];
    word_t  rx_q [$];
    word_t  lfsr;
    int     cycle_cnt;

    gpu_top #(
        .MEM_WORDS    (MEM_WORDS),
        .TIMEOUT_UNIT (TIMEOUT_UNIT)
    ) u_gpu_top (
        .clk        (clk),
        .rst        (rst),
        .recv_instr (recv_instr),
        .in_data    (in_data),
        .out_data   (out_data),
        .out_valid  (out_valid),
        .busy       (busy)
    );

    initial begin
        clk = 1'b0;
    end

    always #4 clk = ~clk;

    // run limit
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Finished with errors");
            $fatal(1, "cycle limit reached");
        end
    end

    // galois lfsr, one step per bit taken
    function automatic word_t rand_bits(input int n);
        word_t r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            r    = {r[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
        end
        return r;
    endfunction

    // opcode in the top nibble, argument in the low half
    function automatic word_t kword(input kernel_op_e op, input int arg);
        return (word_t'(op) << KOP_LSB) | (word_t'(arg) & 32'h0000ffff);
    endfunction

    function automatic word_t random_op();
        word_t sel;
        sel = rand_bits(2);
        case (sel)
            0: return kword(LOAD, OPND_BASE + rand_bits(4));
            1: return kword(ADD, OPND_BASE + rand_bits(4));
            2: return kword(ADDI, rand_bits(16));
            default: return kword(STORE, STORE_BASE + rand_bits(4));
        endcase
    endfunction

    task automatic check(input string name, input word_t exp, input word_t act);
        if (exp !== act) begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            $display("Finished with errors");
            $fatal(1, "mismatch in %s", name);
        end
    endtask

    // reference interpreter on the shadow memory
    task automatic model_run(input int pc_start);
        int     pc;
        int     idx;
        word_t  acc;
        word_t  w;
        pc  = pc_start;
        acc = '0;
        for (int step = 0; step < 1000; step++) begin
            w   = shadow[pc];
            idx = w[KARG_W-1:0] % MEM_WORDS;
            pc  = (pc + 1) % MEM_WORDS;
            case (w[KOP_MSB:KOP_LSB])
                HALT: return;
                LOAD: acc = shadow[idx];
                ADD: acc = acc + shadow[idx];
                STORE: shadow[idx] = acc;
                // sign extended immediate
                ADDI: acc = acc + {{(32 - KARG_W){w[KARG_W-1]}}, w[KARG_W-1:0]};
                JNZ: pc = (acc != '0) ? idx : pc;
                JMP: pc = idx;
                default: ;
            endcase
        end
        $display("reference kernel did not reach HALT");
        $display("Finished with errors");
        $fatal(1, "model step limit");
    endtask

    // one command, params and copy data, then collect output until idle
    task automatic run_cmd(input host_op_e op, input word_t p0, input word_t p1);
        rx_q.delete();
        @(posedge clk);
        recv_instr <= op;
        @(posedge clk);
        recv_instr <= NOP;
        in_data    <= p0;
        @(negedge clk);
        check("busy after accept", 1, busy);
        @(posedge clk);
        in_data <= p1;
        if (op == COPY_TO_GPU) begin
            foreach (buf_q[k]) begin
                @(posedge clk);
                in_data <= buf_q[k];
            end
        end
        @(posedge clk);
        in_data <= '0;
        forever begin
            @(negedge clk);
            if (out_valid) begin
                check("out_valid without busy", 1, busy);
                rx_q.push_back(out_data);
            end
            if (!busy) begin
                break;
            end
        end
    endtask

    // low two bits of address and count are junk, the controller drops them
    task automatic copy_in(input int widx);
        foreach (buf_q[k]) begin
            shadow[(widx + k) % MEM_WORDS] = buf_q[k];
        end
        run_cmd(COPY_TO_GPU, (word_t'(widx) << 2) | rand_bits(2),
                (word_t'(buf_q.size()) << 2) | rand_bits(2));
        check("copy in output count", 0, rx_q.size());
    endtask

    task automatic read_check(input string name, input int widx, input int n);
        run_cmd(COPY_FROM_GPU, (word_t'(widx) << 2) | rand_bits(2),
                (word_t'(n) << 2) | rand_bits(2));
        check({name, " word count"}, n, rx_q.size());
        foreach (rx_q[k]) begin
            check(name, shadow[(widx + k) % MEM_WORDS], rx_q[k]);
        end
    endtask

    task automatic launch(input string name, input int pc, input word_t t, input word_t exp);
        run_cmd(KERNEL_LAUNCH, word_t'(pc) << 2, t);
        check({name, " status count"}, 1, rx_q.size());
        check(name, exp, rx_q[0]);
    endtask

    // nop or unknown opcodes, nothing may happen
    task automatic idle_gap(input int n);
        word_t junk;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            if (rand_bits(1) == '0) begin
                junk = NOP;
            end else begin
                junk = rand_bits(32) | 32'h4;
            end
            recv_instr <= junk;
            in_data    <= rand_bits(32);
            @(negedge clk);
            check("busy while idle", 0, busy);
            check("out_valid while idle", 0, out_valid);
        end
        @(posedge clk);
        recv_instr <= NOP;
        @(negedge clk);
        check("busy after idle", 0, busy);
    endtask

    initial begin
        int widx [8];
        int nw [8];
        int n;
        int pc;
        lfsr       = 32'hbb8b1dbd;
        cycle_cnt  = 0;
        rst        = 1'b0;
        recv_instr = NOP;
        in_data    = '0;
        repeat (2) @(posedge clk);
        rst <= 1'b1;

        // copy round trip, regions kept below the kernel areas
        for (int r = 0; r < 8; r++) begin
            widx[r] = rand_bits(9);
            nw[r]   = rand_bits(4) + 1;
            buf_q.delete();
            repeat (nw[r]) buf_q.push_back(rand_bits(32));
            copy_in(widx[r]);
            idle_gap(rand_bits(3));
        end
        for (int r = 0; r < 8; r++) begin
            read_check("copy round trip", widx[r], nw[r]);
            idle_gap(rand_bits(3));
        end

        // straight-line kernels
        for (int r = 0; r < 3; r++) begin
            buf_q.delete();
            repeat (32) buf_q.push_back(rand_bits(32));
            copy_in(OPND_BASE);
            buf_q.delete();
            buf_q.push_back(kword(LOAD, OPND_BASE + rand_bits(4)));
            n = rand_bits(3) + 4;
            repeat (n) buf_q.push_back(random_op());
            buf_q.push_back(kword(STORE, STORE_BASE + rand_bits(4)));
            buf_q.push_back(kword(HALT, 0));
            copy_in(PROG_BASE);
            model_run(PROG_BASE);
            launch("kernel arithmetic", PROG_BASE, 8, ST_HALTED);
            read_check("kernel stores", STORE_BASE, 16);
        end

        // countdown loop, acc starts at zero
        for (int r = 0; r < 2; r++) begin
            buf_q.delete();
            buf_q.push_back(kword(ADDI, rand_bits(4) + 1));
            buf_q.push_back(kword(STORE, STORE_BASE + 1));
            buf_q.push_back(kword(ADDI, 16'hffff));
            buf_q.push_back(kword(STORE, STORE_BASE));
            buf_q.push_back(kword(JNZ, PROG_BASE + 2));
            buf_q.push_back(kword(ADDI, rand_bits(16)));
            buf_q.push_back(kword(STORE, STORE_BASE + 2));
            buf_q.push_back(kword(HALT, 0));
            copy_in(PROG_BASE);
            model_run(PROG_BASE);
            launch("loop kernel", PROG_BASE, 0, ST_HALTED);
            read_check("loop kernel stores", STORE_BASE, 3);
        end

        // jump to self until the watchdog fires
        for (int r = 0; r < 2; r++) begin
            pc = PROG_BASE + 8 + r;
            buf_q.delete();
            buf_q.push_back(kword(JMP, pc));
            copy_in(pc);
            launch("timeout kernel", pc, r + 1, ST_TIMEOUT);
        end

        // controller and core must be usable again
        widx[0] = rand_bits(9);
        buf_q.delete();
        repeat (16) buf_q.push_back(rand_bits(32));
        copy_in(widx[0]);
        read_check("copy after timeout", widx[0], 16);

        $display("Finished with no errors");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
logic/gpu_pkg.sv
logic/device_mem.sv
logic/host_controller.sv
logic/accum_core.sv
logic/gpu_top.sv
verif/gpu_properties.sv
verif/gpu_tb.sv
